// ==== build.f ====
awg_pkg.sv
wave_write_if.sv
prbs_generator.sv
waveform_ram.sv
waveform_loader.sv
apb_registers.sv
waveform_player.sv
function_generator.sv
function_generator_assert.sv
function_generator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module function_generator_tb -f build.f -o function_generator_sim
# the log decides, not the exit code of the simulation
./obj_dir/function_generator_sim | tee sim.log
if grep -qx "Result: PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// ==== function_generator_tb.sv ====
`default_nettype none

module function_generator_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import awg_pkg::*;

	localparam int clock_period = 40;
	localparam int reset_cycles = 8;
	localparam int memory_depth = 2 ** address_width;
	localparam int play_last = 40;
	// words checked in each playback test
	localparam int marker_words = 45;
	localparam int host_words = 41;
	localparam int prbs_words = 45;
	localparam int strobe_limit = 24;
	localparam int margin_cycles = 4000;
	// two fills, every played word, then slack for apb traffic
	localparam int timeout_cycles = 2 * memory_depth +
		8 * (marker_words + host_words + prbs_words) + margin_cycles;

	logic clock;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_address_width-1:0] paddr;
	wave_word_t pwdata;
	wave_word_t prdata;
	logic pready;
	logic pslverr;
	logic bit_out;
	wave_word_t word_out;
	logic word_strobe;

	// expected contents of the waveform memory
	wave_word_t expected_memory [memory_depth];
	logic [31:0] lfsr_state;
	time release_time;
	time access_done_time;
	int word_errors;
	int bit_errors;
	int status_errors;
	int other_errors;
	int total_errors;

	function_generator function_generator_inst (
		.clock(clock),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.bit_out(bit_out),
		.word_out(word_out),
		.word_strobe(word_strobe)
	);

	initial clock = 1'b0;
	always #(clock_period / 2) clock = ~clock;

	// 32-bit fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// one lfsr step per bit taken
	task automatic random_word(output wave_word_t value);
		value = '0;
		for (int b = 0; b < data_width; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[data_width-2:0], lfsr_state[0]};
		end
	endtask

	// block header: ff, high address, low address, ff, then zeros
	function automatic wave_word_t marker_word(input wave_address_t address);
		case (address[4:0])
			5'd0: return 8'hff;
			5'd1: return address[10:3];
			5'd2: return {5'b00000, address[2:0]};
			5'd3: return 8'hff;
			default: return 8'h00;
		endcase
	endfunction

	// prbs-7, x^7 + x^6 + 1 from the seed, first bit into the msb
	task automatic prbs_fill_model();
		logic [6:0] state;
		logic feedback;
		wave_word_t word;
		state = prbs_seed;
		word = '0;
		for (int a = 0; a < memory_depth; a++) begin
			for (int b = data_width - 1; b >= 0; b--) begin
				feedback = state[6] ^ state[5];
				word[b] = feedback;
				state = {state[5:0], feedback};
			end
			expected_memory[a] = word;
		end
	endtask

	function automatic logic [apb_address_width-1:0] window_address(input wave_address_t address);
		return {1'b1, 1'b0, address};
	endfunction

	task automatic check_word(input wave_word_t actual, input wave_word_t expected,
		input string name);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			word_errors++;
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string name);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
			bit_errors++;
		end
	endtask

	task automatic check_status(input wave_word_t data, input logic err,
		input wave_word_t expected_data, input logic expected_err, input string name);
		if (data !== expected_data) begin
			$display("mismatch at %0t: prdata (%s) is %h, expected %h", $time, name, data,
				expected_data);
			status_errors++;
		end
		if (err !== expected_err) begin
			$display("mismatch at %0t: pslverr (%s) is %b, expected %b", $time, name, err,
				expected_err);
			status_errors++;
		end
	endtask

	// setup phase, then access until pready
	task automatic apb_write(input logic [apb_address_width-1:0] address, input wave_word_t data);
		@(posedge clock);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= address;
		pwdata <= data;
		@(posedge clock);
		penable <= 1'b1;
		@(negedge clock);
		// window writes stretch while the loader is busy
		while (!pready) begin
			@(negedge clock);
		end
		access_done_time = $time;
		@(posedge clock);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [apb_address_width-1:0] address, output wave_word_t data,
		output logic err);
		@(posedge clock);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= address;
		@(posedge clock);
		penable <= 1'b1;
		@(negedge clock);
		while (!pready) begin
			@(negedge clock);
		end
		data = prdata;
		err = pslverr;
		access_done_time = $time;
		@(posedge clock);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// follow the looping address, each word msb first over 8 clocks
	task automatic play_words(input int count, input int last);
		wave_address_t address;
		wave_word_t word;
		int waited;
		address = '0;
		for (int n = 0; n < count; n++) begin
			waited = 0;
			@(negedge clock);
			while (!word_strobe && waited < strobe_limit) begin
				waited++;
				@(negedge clock);
			end
			if (!word_strobe) begin
				$display("no word strobe within %0d cycles at %0t", strobe_limit, $time);
				other_errors++;
				return;
			end
			word = word_out;
			check_word(word, expected_memory[address], "word_out");
			check_bit(bit_out, word[7], "bit_out");
			for (int b = data_width - 2; b >= 0; b--) begin
				@(negedge clock);
				check_bit(bit_out, word[b], "bit_out");
			end
			address = (address == wave_address_t'(last)) ? '0 : address + 1'b1;
		end
	endtask

	// player halts at the next word boundary
	task automatic stop_playback(input wave_word_t control_value);
		apb_write(control_offset, control_value);
		repeat (16) @(posedge clock);
	endtask

	task automatic wait_filled();
		wave_word_t data;
		logic err;
		int polls;
		data = '0;
		polls = 0;
		while (!data[0] && polls < memory_depth) begin
			apb_read(status_offset, data, err);
			polls++;
		end
		if (!data[0]) begin
			$display("fill still running after %0d status reads", polls);
			other_errors++;
		end
	endtask

	task automatic fill_and_backpressure();
		wave_word_t data;
		wave_word_t value;
		logic err;
		for (int a = 0; a < memory_depth; a++) begin
			expected_memory[a] = marker_word(wave_address_t'(a));
		end
		// reset values
		@(negedge clock);
		check_bit(pready, 1'b0, "pready");
		check_bit(pslverr, 1'b0, "pslverr");
		check_bit(word_strobe, 1'b0, "word_strobe");
		check_bit(bit_out, 1'b0, "bit_out");
		check_word(word_out, 8'h00, "word_out");
		apb_read(status_offset, data, err);
		check_status(data, err, 8'h00, 1'b0, "status during fill");
		apb_read(control_offset, data, err);
		check_status(data, err, 8'h00, 1'b0, "control after reset");
		apb_read(last_address_offset, data, err);
		check_status(data, err, 8'h00, 1'b0, "last address after reset");
		// issued mid fill, held off until the sweep ends
		// lands inside the played range so the marker playback sees it
		random_word(value);
		apb_write(window_address(11'd20), value);
		expected_memory[20] = value;
		if (access_done_time - release_time < memory_depth * clock_period) begin
			$display("window write finished at %0t while the fill was still running",
				access_done_time);
			other_errors++;
		end
		apb_read(status_offset, data, err);
		check_status(data, err, 8'h01, 1'b0, "status after fill");
	endtask

	task automatic marker_playback();
		apb_write(last_address_offset, 8'(play_last));
		apb_write(control_offset, 8'h01);
		// runs past the last address to see the wrap
		play_words(marker_words, play_last);
		stop_playback(8'h00);
	endtask

	task automatic host_write_playback();
		wave_word_t value;
		for (int a = 5; a <= 9; a++) begin
			random_word(value);
			apb_write(window_address(wave_address_t'(a)), value);
			expected_memory[a] = value;
		end
		apb_write(control_offset, 8'h01);
		play_words(host_words, play_last);
		stop_playback(8'h00);
	endtask

	task automatic prbs_playback();
		wave_word_t data;
		logic err;
		// fill_mode and refill, run off
		apb_write(control_offset, 8'h06);
		prbs_fill_model();
		wait_filled();
		// refill reads back cleared
		apb_read(control_offset, data, err);
		check_status(data, err, 8'h02, 1'b0, "control after refill");
		apb_write(control_offset, 8'h03);
		play_words(prbs_words, play_last);
	endtask

	task automatic errors_and_stop();
		wave_word_t data;
		wave_word_t last_word;
		logic err;
		apb_read(12'h00c, data, err);
		check_status(data, err, 8'h00, 1'b1, "undefined offset");
		apb_read(window_address(11'd5), data, err);
		check_status(data, err, 8'h00, 1'b1, "window read");
		apb_read(last_address_offset, data, err);
		check_status(data, err, 8'(play_last), 1'b0, "last address");
		apb_write(control_offset, 8'h02);
		@(negedge clock);
		last_word = word_out;
		// one more word may still go out before the boundary
		repeat (16) begin
			@(negedge clock);
			if (word_strobe) begin
				last_word = word_out;
			end
		end
		repeat (40) begin
			@(negedge clock);
			check_bit(word_strobe, 1'b0, "word_strobe");
			check_word(word_out, last_word, "word_out");
		end
	endtask

	initial begin
		reset <= 1'b1;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		lfsr_state = 32'd69756;
		word_errors = 0;
		bit_errors = 0;
		status_errors = 0;
		other_errors = 0;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
		release_time = $time;
		fill_and_backpressure();
		marker_playback();
		host_write_playback();
		prbs_playback();
		errors_and_stop();
		total_errors = word_errors + bit_errors + status_errors + other_errors +
			function_generator_inst.assertions_inst.failure_count;
		$display("errors: word %0d, bit %0d, status %0d, other %0d, assertion %0d",
			word_errors, bit_errors, status_errors, other_errors,
			function_generator_inst.assertions_inst.failure_count);
		if (total_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// hard stop if a handshake never completes
	initial begin
		#(timeout_cycles * clock_period);
		$display("watchdog expired after %0d cycles, tests did not finish", timeout_cycles);
		$display("Result: FAILED");
		$finish;
	end
endmodule

`default_nettype wire

// ==== function_generator_assert.sv ====
`default_nettype none

module function_generator_assert (
	input logic clock,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic word_strobe,
	input logic run,
	input logic filled,
	input logic write_valid,
	input logic write_ready,
	input awg_pkg::wave_address_t host_address,
	input logic ram_write_enable,
	input awg_pkg::wave_address_t ram_write_address
);
	timeunit 1ns;
	timeprecision 1ps;

	int failure_count = 0;

	// completion only in an access phase
	pready_in_access: assert property (@(posedge clock) disable iff (reset)
		!(psel && penable) |-> !pready)
	else begin
		$error("pready high outside an access phase");
		failure_count++;
	end

	// no second strobe inside one word
	strobe_gap: assert property (@(posedge clock) disable iff (reset)
		word_strobe |-> !($past(word_strobe, 1) || $past(word_strobe, 2) ||
		$past(word_strobe, 3) || $past(word_strobe, 4) || $past(word_strobe, 5) ||
		$past(word_strobe, 6) || $past(word_strobe, 7)))
	else begin
		$error("word strobes closer than 8 cycles");
		failure_count++;
	end

	// run held at the boundary means the next word follows at 8
	strobe_period: assert property (@(posedge clock) disable iff (reset)
		$past(word_strobe, 8) && $past(run) |-> word_strobe)
	else begin
		$error("word strobe missing 8 cycles after the last one");
		failure_count++;
	end

	// a granted host write owns the memory port, so no sweep is writing
	fill_write: assert property (@(posedge clock) disable iff (reset)
		write_valid && write_ready |->
		filled && ram_write_enable && ram_write_address == host_address)
	else begin
		$error("host write transferred during a fill");
		failure_count++;
	end
endmodule

bind function_generator function_generator_assert assertions_inst (
	.clock(clock),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.word_strobe(word_strobe),
	.run(control.run),
	.filled(filled),
	.write_valid(wave_write.valid),
	.write_ready(wave_write.ready),
	.host_address(wave_write.address),
	.ram_write_enable(write_enable),
	.ram_write_address(write_address)
);

`default_nettype wire

// ==== function_generator.sv ====
`default_nettype none

module function_generator (
	input logic clock,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [awg_pkg::apb_address_width-1:0] paddr,
	input awg_pkg::wave_word_t pwdata,
	output awg_pkg::wave_word_t prdata,
	output logic pready,
	output logic pslverr,
	output logic bit_out,
	output awg_pkg::wave_word_t word_out,
	output logic word_strobe
);
	import awg_pkg::*;

	control_t control;
	logic [last_address_width-1:0] last_address;
	logic filled;
	logic write_enable;
	wave_address_t write_address;
	wave_word_t write_data;
	wave_address_t read_address;
	wave_word_t read_data;

	// host writes toward the memory
	wave_write_if wave_write ();

	apb_registers apb_registers_inst (
		.clock(clock),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.host(wave_write.host),
		.control(control),
		.last_address(last_address),
		.filled(filled)
	);

	waveform_loader waveform_loader_inst (
		.clock(clock),
		.reset(reset),
		.refill(control.refill),
		.fill_mode(control.fill_mode),
		.host(wave_write.store),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data),
		.filled(filled)
	);

	waveform_ram waveform_ram_inst (
		.clock(clock),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data),
		.read_address(read_address),
		.read_data(read_data)
	);

	waveform_player waveform_player_inst (
		.clock(clock),
		.reset(reset),
		.run(control.run),
		.last_address(last_address),
		.read_address(read_address),
		.read_data(read_data),
		.bit_out(bit_out),
		.word_out(word_out),
		.word_strobe(word_strobe)
	);
endmodule

`default_nettype wire

// ==== waveform_player.sv ====
`default_nettype none

module waveform_player (
	input logic clock,
	input logic reset,
	input logic run,
	input logic [awg_pkg::last_address_width-1:0] last_address,
	output awg_pkg::wave_address_t read_address,
	input awg_pkg::wave_word_t read_data,
	output logic bit_out,
	output awg_pkg::wave_word_t word_out,
	output logic word_strobe
);
	import awg_pkg::*;

	localparam int count_width = $clog2(data_width);
	localparam logic [count_width-1:0] last_bit = count_width'(data_width - 1);

	logic active;
	logic primed;
	logic boundary;
	logic load;
	logic [count_width-1:0] bit_count;
	wave_word_t shift;
	wave_address_t next_address;

	// last bit of the current word
	assign boundary = active && (bit_count == last_bit);

	// from idle, wait until read_data reflects address 0
	assign load = run && (boundary || (!active && primed));

	// loop 0 .. last_address
	assign next_address = (read_address == wave_address_t'(last_address)) ?
		'0 : read_address + 1'b1;

	// msb first
	assign bit_out = shift[data_width-1];

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			primed <= 1'b0;
			bit_count <= '0;
			read_address <= '0;
			shift <= '0;
			word_out <= '0;
			word_strobe <= 1'b0;
		end else begin
			word_strobe <= load;
			// one idle clock lets the ram catch up after address returns to 0
			primed <= !active;
			if (load) begin
				active <= 1'b1;
				bit_count <= '0;
				shift <= read_data;
				word_out <= read_data;
				// prefetch, ram has 7 clocks to deliver the next word
				read_address <= next_address;
			end else begin
				shift <= {shift[data_width-2:0], 1'b0};
				if (boundary) begin
					// run dropped, stop here and rewind
					active <= 1'b0;
					bit_count <= '0;
					read_address <= '0;
				end else if (active) begin
					bit_count <= bit_count + 1'b1;
				end
			end
		end
	end
endmodule

`default_nettype wire

// ==== apb_registers.sv ====
`default_nettype none

module apb_registers (
	input logic clock,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [awg_pkg::apb_address_width-1:0] paddr,
	input awg_pkg::wave_word_t pwdata,
	output awg_pkg::wave_word_t prdata,
	output logic pready,
	output logic pslverr,
	wave_write_if.host host,
	output awg_pkg::control_t control,
	output logic [awg_pkg::last_address_width-1:0] last_address,
	input logic filled
);
	import awg_pkg::*;

	logic access;
	logic in_window;
	logic reg_hit;
	logic [offset_width-1:0] offset;

	// access phase of any transfer
	assign access = psel & penable;
	assign in_window = paddr[window_bit];
	assign offset = paddr[offset_width-1:0];

	// only three defined offsets outside the window
	assign reg_hit = !in_window &&
		(offset == control_offset ||
		offset == last_address_offset ||
		offset == status_offset);

	// window writes become requests, apb holds addr and data stable
	assign host.valid = access & pwrite & in_window;
	assign host.address = paddr[address_width-1:0];
	assign host.data = pwdata;

	// window writes stretch until the loader takes them
	assign pready = access & (!(pwrite & in_window) | host.ready);

	// window is write only
	assign pslverr = access & ((in_window & !pwrite) | (!in_window & !reg_hit));

	// read mux
	always_comb begin
		prdata = '0;
		if (access && !pwrite && !in_window) begin
			case (offset)
				control_offset: prdata = {{(data_width - control_width){1'b0}}, control};
				last_address_offset: prdata = last_address;
				// bit 0 is filled, zero while a fill runs
				status_offset: prdata = {{(data_width - 1){1'b0}}, filled};
				default: prdata = '0;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			control <= '0;
			last_address <= '0;
		end else begin
			// refill is a one-clock strobe
			control.refill <= 1'b0;
			if (access && pwrite && reg_hit) begin
				case (offset)
					control_offset: control <= pwdata[control_width-1:0];
					last_address_offset: last_address <= pwdata[last_address_width-1:0];
					// status is read only
					default: begin
					end
				endcase
			end
		end
	end
endmodule

`default_nettype wire

// ==== waveform_loader.sv ====
`default_nettype none

module waveform_loader (
	input logic clock,
	input logic reset,
	input logic refill,
	input logic fill_mode,
	wave_write_if.store host,
	output logic write_enable,
	output awg_pkg::wave_address_t write_address,
	output awg_pkg::wave_word_t write_data,
	output logic filled
);
	import awg_pkg::*;

	localparam int offset_bits = $clog2(block_length);
	localparam wave_address_t last_fill_address = '1;

	logic filling;
	logic fill_prbs;
	wave_address_t fill_address;
	wave_word_t marker_data;
	wave_word_t prbs_word;

	// restart lines up the seed with the first fill word
	prbs_generator prbs_generator_inst (
		.clock(clock),
		.reset(reset),
		.restart(refill),
		.step(filling & fill_prbs),
		.word(prbs_word)
	);

	// marker header at the start of every 32-word block
	always_comb begin
		case (fill_address[offset_bits-1:0])
			0: marker_data = marker_value;
			// upper address bits
			1: marker_data = fill_address[address_width-1 -: data_width];
			// remaining low bits, zero extended
			2: marker_data = {{(2 * data_width - address_width){1'b0}},
				fill_address[address_width-data_width-1:0]};
			3: marker_data = marker_value;
			default: marker_data = '0;
		endcase
	end

	// fill sweep, armed by reset so it runs right after release
	always_ff @(posedge clock) begin
		if (reset) begin
			filling <= 1'b1;
			fill_prbs <= 1'b0;
			fill_address <= '0;
			filled <= 1'b0;
		end else if (refill) begin
			filling <= 1'b1;
			fill_prbs <= fill_mode;
			fill_address <= '0;
			filled <= 1'b0;
		end else if (filling) begin
			fill_address <= fill_address + 1'b1;
			// last word goes out this cycle
			if (fill_address == last_fill_address) begin
				filling <= 1'b0;
				filled <= 1'b1;
			end
		end
	end

	// host is held off for the whole sweep
	assign host.ready = !filling;

	// fill owns the write port, otherwise host writes pass through
	always_comb begin
		if (filling) begin
			write_enable = 1'b1;
			write_address = fill_address;
			write_data = fill_prbs ? prbs_word : marker_data;
		end else begin
			write_enable = host.valid & host.ready;
			write_address = host.address;
			write_data = host.data;
		end
	end
endmodule

`default_nettype wire

// ==== waveform_ram.sv ====
`default_nettype none

module waveform_ram (
	input logic clock,
	input logic write_enable,
	input awg_pkg::wave_address_t write_address,
	input awg_pkg::wave_word_t write_data,
	input awg_pkg::wave_address_t read_address,
	output awg_pkg::wave_word_t read_data
);
	import awg_pkg::*;

	// 2048 x 8, maps onto one block ram
	wave_word_t memory [0:(2**address_width)-1];

	always_ff @(posedge clock) begin
		if (write_enable) begin
			memory[write_address] <= write_data;
		end
	end

	// registered read, one clock of latency
	always_ff @(posedge clock) begin
		read_data <= memory[read_address];
	end
endmodule

`default_nettype wire

// ==== prbs_generator.sv ====
`default_nettype none

module prbs_generator (
	input logic clock,
	input logic reset,
	input logic restart,
	input logic step,
	output awg_pkg::wave_word_t word
);
	import awg_pkg::*;

	logic [prbs_order-1:0] state;
	logic [prbs_order-1:0] lfsr;
	logic [prbs_order-1:0] next_state;
	logic feedback;
	wave_word_t next_bits;

	// run the lfsr eight times ahead, earliest bit lands in the msb
	always_comb begin
		lfsr = state;
		next_bits = '0;
		feedback = 1'b0;
		for (int i = data_width - 1; i >= 0; i--) begin
			feedback = lfsr[prbs_tap_high] ^ lfsr[prbs_tap_low];
			next_bits[i] = feedback;
			lfsr = {lfsr[prbs_order-2:0], feedback};
		end
		next_state = lfsr;
	end

	always_ff @(posedge clock) begin
		if (reset || restart) begin
			state <= prbs_seed;
		end else if (step) begin
			state <= next_state;
		end
	end

	// word is valid before the step that consumes it
	assign word = next_bits;
endmodule

`default_nettype wire

// ==== wave_write_if.sv ====
`default_nettype none

interface wave_write_if;
	import awg_pkg::*;

	// host request, held until ready
	logic valid;
	wave_address_t address;
	wave_word_t data;
	// low while the loader is filling
	logic ready;

	modport host (
		output valid, address, data,
		input ready
	);

	modport store (
		input valid, address, data,
		output ready
	);
endinterface

`default_nettype wire

// ==== awg_pkg.sv ====
`default_nettype none

package awg_pkg;
	// waveform word and memory depth
	localparam int data_width = 8;
	localparam int address_width = 11;

	// apb address map
	localparam int apb_address_width = 13;
	// set for the memory window, clear for registers
	localparam int window_bit = 12;
	localparam int offset_width = 12;
	localparam logic [offset_width-1:0] control_offset = 12'h000;
	localparam logic [offset_width-1:0] last_address_offset = 12'h004;
	localparam logic [offset_width-1:0] status_offset = 12'h008;
	localparam int last_address_width = 8;

	// framing marker pattern
	localparam int block_length = 32;
	localparam logic [data_width-1:0] marker_value = 8'hff;

	// prbs-7, x^7 + x^6 + 1
	localparam int prbs_order = 7;
	localparam logic [prbs_order-1:0] prbs_seed = 7'h7f;
	localparam int prbs_tap_high = 6;
	localparam int prbs_tap_low = 5;

	typedef logic [data_width-1:0] wave_word_t;
	typedef logic [address_width-1:0] wave_address_t;

	// run sits in bit 0, fill_mode in bit 1, refill in bit 2
	typedef struct packed {
		logic refill;
		logic fill_mode;
		logic run;
	} control_t;

	localparam int control_width = $bits(control_t);
endpackage

`default_nettype wire
